/* pi1_axi4_cfg.svh */
/* Build-time sizing for the PI1 to AXI4 bridge. PI1_ARCH_BITS must be a power of two,
   16 or more, and SRAM_WORDS should be a power of two so the address wrap stays cheap */
`ifndef PI1_AXI4_CFG_SVH
`define PI1_AXI4_CFG_SVH

// Data word width in bits
`define PI1_ARCH_BITS 32

// Number of PI1 masters sharing the bridge
`define PI1_MASTER_CNT 2

// SRAM depth in words
`define SRAM_WORDS 64

// Entries in each SRAM channel queue
`define CHAN_FIFO_DEPTH 2

// Word address width, byte offset bits dropped
`define PI1_ADDR_BITS (`PI1_ARCH_BITS - $clog2(`PI1_ARCH_BITS / 8))

`endif

/* pi1_pkg.sv */
/* PI1 and AXI4 channel types. AXI4 carries single beats only, so no ID, burst,
   cache, protection, lock or QoS fields exist and no error response is modeled */
`include "pi1_axi4_cfg.svh"

package pi1_pkg;

	// PI1 operation codes, same encoding as the bus
	typedef enum logic [1:0] {
		NOP = 2'b00,
		WR  = 2'b01,
		RD  = 2'b10,
		RW  = 2'b11
	} pi1_op_e;

	// One PI1 request as held by a master
	typedef struct packed {
		pi1_op_e                            op;
		logic [`PI1_ADDR_BITS-1:0]          addr;
		logic [`PI1_ARCH_BITS-1:0]          data;
		logic [(`PI1_ARCH_BITS / 8)-1:0]    sel;
	} pi1_req_t;

	// AW or AR payload, byte address
	typedef struct packed {
		logic [`PI1_ARCH_BITS-1:0] addr;
	} axi4_ax_t;

	// W payload, one full beat
	typedef struct packed {
		logic [`PI1_ARCH_BITS-1:0]       data;
		logic [(`PI1_ARCH_BITS / 8)-1:0] strb;
	} axi4_w_t;

	// Master to slave signals
	typedef struct packed {
		logic     aw_valid;
		axi4_ax_t aw;
		logic     w_valid;
		axi4_w_t  w;
		logic     b_ready;
		logic     ar_valid;
		axi4_ax_t ar;
		logic     r_ready;
	} axi4_req_t;

	// Slave to master signals
	typedef struct packed {
		logic                      aw_ready;
		logic                      w_ready;
		logic                      b_valid;
		logic                      ar_ready;
		logic                      r_valid;
		logic [`PI1_ARCH_BITS-1:0] r_data;
	} axi4_rsp_t;

endpackage

/* axi4_chan_fifo.sv */
/* Single-clock queue for one AXI4 channel. The head is shown combinationally on
   pop_data_o; push while full or pop while empty is a caller error */
module axi4_chan_fifo #(
	parameter type T     = logic,
	parameter int  DEPTH = 2
) (
	input  logic axi4_clk_i,
	input  logic reset_i,
	input  logic push_i,
	input  T     push_data_i,
	output logic full_o,
	input  logic pop_i,
	output T     pop_data_o,
	output logic empty_o
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	// Storage, payload only
	T mem [DEPTH];

	logic [PTR_BITS-1:0] wr_ptr_q;
	logic [PTR_BITS-1:0] rd_ptr_q;
	logic [PTR_BITS:0]   count_q;

	assign full_o     = (count_q == (PTR_BITS + 1)'(DEPTH));
	assign empty_o    = (count_q == '0);
	assign pop_data_o = mem[rd_ptr_q];

	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			// Pointers wrap at DEPTH, which need not be a power of two
			if (push_i) begin
				wr_ptr_q <= (wr_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
			end
			if (pop_i) begin
				rd_ptr_q <= (rd_ptr_q == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
			end
			// Simultaneous push and pop leaves the count alone
			if (push_i && !pop_i) begin
				count_q <= count_q + 1'b1;
			end else if (pop_i && !push_i) begin
				count_q <= count_q - 1'b1;
			end
		end
	end

	always_ff @(posedge axi4_clk_i) begin
		if (push_i) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	// The channel owner must honor the flags
	a_no_overflow: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		push_i |-> !full_o);
	a_no_underflow: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		pop_i |-> !empty_o);

endmodule

/* pi1_arbiter.sv */
/* Round-robin share of one PI1 slave port. A result that returns while its owner
   already holds a new, ungranted request is parked and handed over on a later rdy */
`include "pi1_axi4_cfg.svh"

module pi1_arbiter import pi1_pkg::*; (
	input  logic                       axi4_clk_i,
	input  logic                       reset_i,
	input  pi1_req_t                   m_req_i [`PI1_MASTER_CNT],
	output logic [`PI1_ARCH_BITS-1:0]  m_data_o [`PI1_MASTER_CNT],
	output logic [`PI1_MASTER_CNT-1:0] m_rdy_o,
	output pi1_req_t                   s_req_o,
	input  logic [`PI1_ARCH_BITS-1:0]  s_data_i,
	input  logic                       s_rdy_i
);
	localparam int N        = `PI1_MASTER_CNT;
	localparam int IDX_BITS = (N > 1) ? $clog2(N) : 1;

	logic [IDX_BITS-1:0]       last_q;
	logic [IDX_BITS-1:0]       owner_q;
	logic                      own_valid_q;
	logic [IDX_BITS-1:0]       grant_idx;
	logic [N-1:0]              grant;
	logic [N-1:0]              req_pend;
	logic [N-1:0]              in_bridge;
	logic [N-1:0]              res_now;
	logic [N-1:0]              done_q;
	logic [`PI1_ARCH_BITS-1:0] data_q [N];

	// Rotating search that starts one past the last served master
	always_comb begin
		int unsigned idx;
		logic        found;
		for (int i = 0; i < N; i++) begin
			req_pend[i] = (m_req_i[i].op != NOP);
		end
		grant     = '0;
		grant_idx = last_q;
		found     = 1'b0;
		for (int k = 1; k <= N; k++) begin
			idx = (int'(last_q) + k) % N;
			if (!found && req_pend[idx]) begin
				found      = 1'b1;
				grant[idx] = 1'b1;
				grant_idx  = IDX_BITS'(idx);
			end
		end
		s_req_o = '0;
		if (found) begin
			s_req_o = m_req_i[grant_idx];
		end
	end

	always_comb begin
		for (int i = 0; i < N; i++) begin
			// Request of master i currently inside the bridge
			in_bridge[i] = own_valid_q && (owner_q == IDX_BITS'(i));
			// Result deliverable now either fresh from the bridge or parked
			res_now[i]   = (in_bridge[i] && s_rdy_i) || done_q[i];
			// Ready needs a free slot and either no request or an accepted one
			m_rdy_o[i]   = (!(in_bridge[i] || done_q[i]) || res_now[i])
				&& (!req_pend[i] || (grant[i] && s_rdy_i));
			if (done_q[i]) begin
				m_data_o[i] = data_q[i];
			end else if (in_bridge[i]) begin
				m_data_o[i] = s_data_i;
			end else begin
				m_data_o[i] = '0;
			end
		end
	end

	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			own_valid_q <= 1'b0;
			owner_q     <= '0;
			last_q      <= IDX_BITS'(N - 1);
			done_q      <= '0;
		end else begin
			// The bridge takes the granted request whenever it is ready
			if (s_rdy_i) begin
				own_valid_q <= |grant;
				if (|grant) begin
					owner_q <= grant_idx;
					last_q  <= grant_idx;
				end
			end
			for (int i = 0; i < N; i++) begin
				if (done_q[i] && m_rdy_o[i]) begin
					done_q[i] <= 1'b0;
				end else if (in_bridge[i] && s_rdy_i && !m_rdy_o[i]) begin
					done_q[i] <= 1'b1;
				end
			end
		end
	end

	// Parked result word
	always_ff @(posedge axi4_clk_i) begin
		for (int i = 0; i < N; i++) begin
			if (in_bridge[i] && s_rdy_i) begin
				data_q[i] <= s_data_i;
			end
		end
	end

	// A parked result leaves before its owner's next request enters the bridge
	a_park_clear: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		(in_bridge & done_q) == '0);

endmodule

/* pi1_to_axi4.sv */
/* PI1 slave to single-beat AXI4 master, one operation in flight. A swap is an AR/R
   pair then an AW/W/B pair at the same address, so it is not atomic on the AXI4 side */
`include "pi1_axi4_cfg.svh"

module pi1_to_axi4 import pi1_pkg::*; (
	input  logic                      axi4_clk_i,
	input  logic                      reset_i,
	input  pi1_req_t                  pi1_req_i,
	output logic [`PI1_ARCH_BITS-1:0] pi1_data_o,
	output logic                      pi1_rdy_o,
	output axi4_req_t                 axi4_req_o,
	input  axi4_rsp_t                 axi4_rsp_i
);
	localparam int BYTES    = `PI1_ARCH_BITS / 8;
	localparam int OFF_BITS = $clog2(BYTES);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RD,
		ST_WR,
		ST_SW_RD,
		ST_SW_WR
	} state_e;

	state_e                    state_q;
	logic                      aw_valid_q;
	logic                      w_valid_q;
	logic                      ar_valid_q;
	logic [`PI1_ARCH_BITS-1:0] ax_addr_q;
	axi4_w_t                   w_q;
	logic [`PI1_ARCH_BITS-1:0] old_q;
	logic [OFF_BITS-1:0]       byte_off;
	logic [`PI1_ARCH_BITS-1:0] byte_addr;
	logic                      acc;
	logic                      aw_fire;
	logic                      w_fire;
	logic                      ar_fire;
	logic                      b_fire;
	logic                      r_fire;

	// Byte offset from the lowest set select bit, zero for an empty select
	always_comb begin
		byte_off = '0;
		for (int k = BYTES - 1; k >= 0; k--) begin
			if (pi1_req_i.sel[k]) begin
				byte_off = OFF_BITS'(k);
			end
		end
		byte_addr = {pi1_req_i.addr, byte_off};
	end

	// Channel outputs straight from the holding registers
	always_comb begin
		axi4_req_o.aw_valid = aw_valid_q;
		axi4_req_o.aw.addr  = ax_addr_q;
		axi4_req_o.w_valid  = w_valid_q;
		axi4_req_o.w        = w_q;
		axi4_req_o.b_ready  = (state_q == ST_WR) || (state_q == ST_SW_WR);
		axi4_req_o.ar_valid = ar_valid_q;
		axi4_req_o.ar.addr  = ax_addr_q;
		axi4_req_o.r_ready  = (state_q == ST_RD) || (state_q == ST_SW_RD);
	end

	assign aw_fire = aw_valid_q && axi4_rsp_i.aw_ready;
	assign w_fire  = w_valid_q && axi4_rsp_i.w_ready;
	assign ar_fire = ar_valid_q && axi4_rsp_i.ar_ready;
	assign b_fire  = axi4_req_o.b_ready && axi4_rsp_i.b_valid;
	assign r_fire  = axi4_req_o.r_ready && axi4_rsp_i.r_valid;

	// Ready when idle or in the closing handshake of the current op
	always_comb begin
		case (state_q)
			ST_IDLE:  pi1_rdy_o = 1'b1;
			ST_RD:    pi1_rdy_o = r_fire;
			ST_WR:    pi1_rdy_o = b_fire;
			ST_SW_WR: pi1_rdy_o = b_fire;
			default:  pi1_rdy_o = 1'b0;
		endcase
	end

	assign acc = pi1_rdy_o && (pi1_req_i.op != NOP);

	// Read returns the R beat, swap the captured old word, write returns zero
	always_comb begin
		pi1_data_o = '0;
		if (state_q == ST_RD && r_fire) begin
			pi1_data_o = axi4_rsp_i.r_data;
		end else if (state_q == ST_SW_WR && b_fire) begin
			pi1_data_o = old_q;
		end
	end

	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			state_q    <= ST_IDLE;
			aw_valid_q <= 1'b0;
			w_valid_q  <= 1'b0;
			ar_valid_q <= 1'b0;
		end else begin
			// Each valid drops on its own transfer
			if (aw_fire) begin
				aw_valid_q <= 1'b0;
			end
			if (w_fire) begin
				w_valid_q <= 1'b0;
			end
			if (ar_fire) begin
				ar_valid_q <= 1'b0;
			end
			if (pi1_rdy_o) begin
				case (pi1_req_i.op)
					RD: begin
						state_q    <= ST_RD;
						ar_valid_q <= 1'b1;
					end
					WR: begin
						state_q    <= ST_WR;
						aw_valid_q <= 1'b1;
						w_valid_q  <= 1'b1;
					end
					RW: begin
						state_q    <= ST_SW_RD;
						ar_valid_q <= 1'b1;
					end
					default: state_q <= ST_IDLE;
				endcase
			end else if (state_q == ST_SW_RD && r_fire) begin
				// Second half of the swap reuses the held address
				state_q    <= ST_SW_WR;
				aw_valid_q <= 1'b1;
				w_valid_q  <= 1'b1;
			end
		end
	end

	// Payloads only load on acceptance, stable while stalled
	always_ff @(posedge axi4_clk_i) begin
		if (acc) begin
			ax_addr_q <= byte_addr;
			w_q.data  <= pi1_req_i.data;
			w_q.strb  <= pi1_req_i.sel;
		end
		if (state_q == ST_SW_RD && r_fire) begin
			old_q <= axi4_rsp_i.r_data;
		end
	end

	// Under back-pressure AW stays up with an unchanged address
	a_aw_hold: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
		axi4_req_o.aw_valid && !axi4_rsp_i.aw_ready
		|=> axi4_req_o.aw_valid && $stable(axi4_req_o.aw));

endmodule

/* axi4_sram.sv */
/* Single-beat AXI4 slave RAM, word array with no reset contents. Addresses wrap
   modulo SRAM_WORDS; a read sees memory before any write committed in the same cycle */
`include "pi1_axi4_cfg.svh"

module axi4_sram import pi1_pkg::*; (
	input  logic      axi4_clk_i,
	input  logic      reset_i,
	input  axi4_req_t axi4_req_i,
	output axi4_rsp_t axi4_rsp_o
);
	localparam int BYTES    = `PI1_ARCH_BITS / 8;
	localparam int OFF_BITS = $clog2(BYTES);
	localparam int IDX_BITS = (`SRAM_WORDS > 1) ? $clog2(`SRAM_WORDS) : 1;

	logic [`PI1_ARCH_BITS-1:0] mem [`SRAM_WORDS];

	axi4_ax_t                  aw_head;
	axi4_w_t                   w_head;
	axi4_ax_t                  ar_head;
	logic                      aw_full;
	logic                      aw_empty;
	logic                      w_full;
	logic                      w_empty;
	logic                      ar_full;
	logic                      ar_empty;
	logic                      wr_commit;
	logic                      rd_pop;
	logic [IDX_BITS-1:0]       wr_idx;
	logic [IDX_BITS-1:0]       rd_idx;
	logic                      b_valid_q;
	logic                      r_valid_q;
	logic [`PI1_ARCH_BITS-1:0] r_data_q;

	// Request channels queue while there is room
	axi4_chan_fifo #(.T(axi4_ax_t), .DEPTH(`CHAN_FIFO_DEPTH)) u_aw_fifo (
		.axi4_clk_i  (axi4_clk_i),
		.reset_i     (reset_i),
		.push_i      (axi4_req_i.aw_valid && !aw_full),
		.push_data_i (axi4_req_i.aw),
		.full_o      (aw_full),
		.pop_i       (wr_commit),
		.pop_data_o  (aw_head),
		.empty_o     (aw_empty)
	);

	axi4_chan_fifo #(.T(axi4_w_t), .DEPTH(`CHAN_FIFO_DEPTH)) u_w_fifo (
		.axi4_clk_i  (axi4_clk_i),
		.reset_i     (reset_i),
		.push_i      (axi4_req_i.w_valid && !w_full),
		.push_data_i (axi4_req_i.w),
		.full_o      (w_full),
		.pop_i       (wr_commit),
		.pop_data_o  (w_head),
		.empty_o     (w_empty)
	);

	axi4_chan_fifo #(.T(axi4_ax_t), .DEPTH(`CHAN_FIFO_DEPTH)) u_ar_fifo (
		.axi4_clk_i  (axi4_clk_i),
		.reset_i     (reset_i),
		.push_i      (axi4_req_i.ar_valid && !ar_full),
		.push_data_i (axi4_req_i.ar),
		.full_o      (ar_full),
		.pop_i       (rd_pop),
		.pop_data_o  (ar_head),
		.empty_o     (ar_empty)
	);

	// Commit needs both write heads and a free B slot
	assign wr_commit = !aw_empty && !w_empty && (!b_valid_q || axi4_req_i.b_ready);
	assign rd_pop    = !ar_empty && (!r_valid_q || axi4_req_i.r_ready);

	// Word index drops the byte bits
	assign wr_idx = IDX_BITS'(aw_head.addr[`PI1_ARCH_BITS-1:OFF_BITS] % `SRAM_WORDS);
	assign rd_idx = IDX_BITS'(ar_head.addr[`PI1_ARCH_BITS-1:OFF_BITS] % `SRAM_WORDS);

	always_ff @(posedge axi4_clk_i) begin
		if (wr_commit) begin
			// Byte lanes merge by strobe
			for (int k = 0; k < BYTES; k++) begin
				if (w_head.strb[k]) begin
					mem[wr_idx][8*k +: 8] <= w_head.data[8*k +: 8];
				end
			end
		end
		if (rd_pop) begin
			r_data_q <= mem[rd_idx];
		end
	end

	// B and R stay up until taken
	always_ff @(posedge axi4_clk_i) begin
		if (reset_i) begin
			b_valid_q <= 1'b0;
			r_valid_q <= 1'b0;
		end else begin
			if (wr_commit) begin
				b_valid_q <= 1'b1;
			end else if (axi4_req_i.b_ready) begin
				b_valid_q <= 1'b0;
			end
			if (rd_pop) begin
				r_valid_q <= 1'b1;
			end else if (axi4_req_i.r_ready) begin
				r_valid_q <= 1'b0;
			end
		end
	end

	assign axi4_rsp_o.aw_ready = !aw_full;
	assign axi4_rsp_o.w_ready  = !w_full;
	assign axi4_rsp_o.b_valid  = b_valid_q;
	assign axi4_rsp_o.ar_ready = !ar_full;
	assign axi4_rsp_o.r_valid  = r_valid_q;
	assign axi4_rsp_o.r_data   = r_data_q;

endmodule

/* pi1_axi4_top.sv */
/* Two PI1 master ports sharing one bridge into the on-chip AXI4 SRAM.
   Each port keeps one request outstanding, all on axi4_clk_i */
`include "pi1_axi4_cfg.svh"

module pi1_axi4_top import pi1_pkg::*; (
	input  logic                       axi4_clk_i,
	input  logic                       reset_i,
	input  pi1_req_t                   m_req_i [`PI1_MASTER_CNT],
	output logic [`PI1_ARCH_BITS-1:0]  m_data_o [`PI1_MASTER_CNT],
	output logic [`PI1_MASTER_CNT-1:0] m_rdy_o
);
	// Arbiter to bridge
	pi1_req_t                  s_req;
	logic [`PI1_ARCH_BITS-1:0] s_data;
	logic                      s_rdy;

	// Bridge to SRAM
	axi4_req_t axi_req;
	axi4_rsp_t axi_rsp;

	pi1_arbiter u_arbiter (
		.axi4_clk_i (axi4_clk_i),
		.reset_i    (reset_i),
		.m_req_i    (m_req_i),
		.m_data_o   (m_data_o),
		.m_rdy_o    (m_rdy_o),
		.s_req_o    (s_req),
		.s_data_i   (s_data),
		.s_rdy_i    (s_rdy)
	);

	pi1_to_axi4 u_bridge (
		.axi4_clk_i (axi4_clk_i),
		.reset_i    (reset_i),
		.pi1_req_i  (s_req),
		.pi1_data_o (s_data),
		.pi1_rdy_o  (s_rdy),
		.axi4_req_o (axi_req),
		.axi4_rsp_i (axi_rsp)
	);

	axi4_sram u_sram (
		.axi4_clk_i (axi4_clk_i),
		.reset_i    (reset_i),
		.axi4_req_i (axi_req),
		.axi4_rsp_o (axi_rsp)
	);

endmodule

/* tb_pi1_axi4.sv */
/* Testbench for pi1_axi4_top with two masters and a reference memory model.
   Every SRAM word is written before random traffic, since the SRAM has no reset contents */
`include "pi1_axi4_cfg.svh"

module tb_pi1_axi4 import pi1_pkg::*; ();
	localparam int N            = `PI1_MASTER_CNT;
	localparam int BYTES        = `PI1_ARCH_BITS / 8;
	localparam int RESET_CYCLES = 10;
	localparam int RAND_OPS     = 400;
	localparam int DIRECTED_OPS = 80;
	// 12 cycles per operation covers a swap plus arbitration slack
	localparam int CYCLE_LIMIT  = (RAND_OPS + DIRECTED_OPS) * 12 + RESET_CYCLES;
	// Own op plus one op of the other master when the result is parked
	localparam int MAX_LAT      = 14;

	logic                      axi4_clk_i;
	logic                      reset_i;
	pi1_req_t                  m_req [N];
	logic [`PI1_ARCH_BITS-1:0] m_data [N];
	logic [N-1:0]              m_rdy;

	// Reference state
	logic [`PI1_ARCH_BITS-1:0] model_mem [`SRAM_WORDS];
	pi1_req_t                  req_q [N][$];
	logic [N-1:0]              outst_q;
	logic [`PI1_ARCH_BITS-1:0] exp_q [N];
	int                        lat_q [N];
	int                        wins_q [N];
	logic                      started_q;
	int                        cycle_q;
	logic [15:0]               lfsr;

	// Aligned select patterns
	logic [BYTES-1:0]          sel_tab [7] = '{4'hf, 4'h3, 4'hc, 4'h1, 4'h2, 4'h4, 4'h8};

	pi1_axi4_top DUT (
		.axi4_clk_i (axi4_clk_i),
		.reset_i    (reset_i),
		.m_req_i    (m_req),
		.m_data_o   (m_data),
		.m_rdy_o    (m_rdy)
	);

	always #10 axi4_clk_i = ~axi4_clk_i;

	task automatic fail_run(input string why);
		$display("Errors found");
		$fatal(1, "%s", why);
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lsb  = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 16'hb400;
			end
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	// Selected bytes take the new data
	function automatic logic [`PI1_ARCH_BITS-1:0] merge_word(input logic [`PI1_ARCH_BITS-1:0] old,
		input logic [`PI1_ARCH_BITS-1:0] nw, input logic [BYTES-1:0] sel);
		logic [`PI1_ARCH_BITS-1:0] res;
		res = old;
		for (int k = 0; k < BYTES; k++) begin
			if (sel[k]) begin
				res[8*k +: 8] = nw[8*k +: 8];
			end
		end
		return res;
	endfunction

	task automatic queue_op(input int m, input pi1_op_e op, input int addr,
		input logic [`PI1_ARCH_BITS-1:0] data, input logic [BYTES-1:0] sel);
		pi1_req_t r;
		r.op   = op;
		r.addr = `PI1_ADDR_BITS'(addr);
		r.data = data;
		r.sel  = sel;
		req_q[m].push_back(r);
	endtask

	// Wait until queues drain, no result is pending and ports are quiet
	task automatic wait_idle();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(negedge axi4_clk_i);
			busy = (outst_q != '0);
			for (int i = 0; i < N; i++) begin
				if (req_q[i].size() != 0 || m_req[i].op != NOP) begin
					busy = 1'b1;
				end
			end
		end
	endtask

	// Acceptances update the model in order with at most one per cycle
	always @(posedge axi4_clk_i) begin : drive_and_model
		logic [N-1:0] acc;
		logic [N-1:0] waits;
		pi1_req_t     r;
		int           idx;
		int           oth;
		if (reset_i) begin
			for (int i = 0; i < N; i++) begin
				m_req[i]  <= '0;
				exp_q[i]  <= '0;
				lat_q[i]  <= 0;
				wins_q[i] <= 0;
			end
			outst_q   <= '0;
			started_q <= 1'b0;
		end else begin
			for (int i = 0; i < N; i++) begin
				acc[i]   = m_rdy[i] && (m_req[i].op != NOP);
				waits[i] = (m_req[i].op != NOP) && !m_rdy[i];
			end
			for (int i = 0; i < N; i++) begin
				r   = m_req[i];
				idx = int'(r.addr) % `SRAM_WORDS;
				oth = (i + 1) % N;
				if (acc[i]) begin
					started_q  <= 1'b1;
					outst_q[i] <= 1'b1;
					lat_q[i]   <= 0;
					case (r.op)
						WR: begin
							exp_q[i]       <= '0;
							model_mem[idx]  = merge_word(model_mem[idx], r.data, r.sel);
						end
						RD: exp_q[i] <= model_mem[idx];
						default: begin
							exp_q[i]       <= model_mem[idx];
							model_mem[idx]  = merge_word(model_mem[idx], r.data, r.sel);
						end
					endcase
				end else if (m_rdy[i]) begin
					outst_q[i] <= 1'b0;
				end else if (outst_q[i]) begin
					lat_q[i] <= lat_q[i] + 1;
				end
				// Accepts in a row while the other master waits
				if (acc[i] && waits[oth]) begin
					wins_q[i] <= wins_q[i] + 1;
				end else if (acc[oth]) begin
					wins_q[i] <= 0;
				end
				if (acc[i] || r.op == NOP) begin
					if (req_q[i].size() > 0) begin
						m_req[i] <= req_q[i].pop_front();
					end else begin
						m_req[i] <= '0;
					end
				end
			end
		end
	end

	always @(posedge axi4_clk_i) begin
		cycle_q <= cycle_q + 1;
		if (cycle_q == CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			fail_run("timeout");
		end
	end

	for (genvar g = 0; g < N; g++) begin : g_chk
		a_result: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
			m_rdy[g] && outst_q[g] |-> m_data[g] == exp_q[g])
		else begin
			$display("Mismatch m_data_o[%0d]: got %h expected %h", g,
				$sampled(m_data[g]), $sampled(exp_q[g]));
			fail_run("result mismatch");
		end
		a_idle_rdy: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
			m_req[g].op == NOP && !outst_q[g] |-> m_rdy[g])
		else begin
			$display("Master %0d idle but its ready is low", g);
			fail_run("idle ready low");
		end
		a_quiet_data: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
			!started_q |-> m_data[g] == '0)
		else begin
			$display("Mismatch m_data_o[%0d]: got %h expected %h", g, $sampled(m_data[g]), 0);
			fail_run("data before any request");
		end
		a_latency: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
			outst_q[g] |-> lat_q[g] <= MAX_LAT)
		else begin
			$display("Master %0d result took longer than %0d cycles", g, MAX_LAT);
			fail_run("latency");
		end
		a_fair: assert property (@(posedge axi4_clk_i) disable iff (reset_i)
			wins_q[g] <= 1)
		else begin
			$display("Master %0d accepted twice while the other master waited", g);
			fail_run("arbitration not fair");
		end
	end

	initial begin
		axi4_clk_i = 1'b0;
		reset_i    <= 1'b1;
		cycle_q    <= 0;
		lfsr       = 16'd81;
		for (int i = 0; i < N; i++) begin
			m_req[i] <= '0;
		end
		repeat (RESET_CYCLES) @(posedge axi4_clk_i);
		reset_i <= 1'b0;
		repeat (3) @(negedge axi4_clk_i);

		// Fill every word with a pattern from the whole address
		for (int a = 0; a < `SRAM_WORDS; a++) begin
			queue_op(a % N, WR, a, 32'h5a3c0000 ^ (a * 32'h01030507), 4'hf);
		end
		wait_idle();

		// Last full-word write from either master wins
		queue_op(0, WR, 5, 32'h11112222, 4'hf);
		queue_op(1, WR, 5, 32'h33334444, 4'hf);
		queue_op(0, RD, 5, '0, 4'hf);
		queue_op(1, RD, 5, '0, 4'hf);
		wait_idle();

		// Byte lanes merge
		queue_op(0, WR, 7, 32'hdeadbeef, 4'h3);
		queue_op(0, WR, 7, 32'hcafef00d, 4'h8);
		queue_op(0, RD, 7, '0, 4'h1);
		wait_idle();

		// Swap returns the old word and the read shows the merged one
		queue_op(1, RW, 9, 32'h89abcdef, 4'hc);
		queue_op(1, RD, 9, '0, 4'hf);
		wait_idle();

		// Mixed traffic with both queues kept full for contention
		for (int n = 0; n < RAND_OPS; n++) begin
			queue_op(n % N, pi1_op_e'(take_bits(2)), int'(take_bits(6)) % `SRAM_WORDS,
				take_bits(32), sel_tab[int'(take_bits(3)) % 7]);
		end
		wait_idle();

		$display("No errors");
		$finish;
	end

endmodule

/* pi1_axi4.f */
+incdir+.
pi1_pkg.sv
axi4_chan_fifo.sv
pi1_arbiter.sv
pi1_to_axi4.sv
axi4_sram.sv
pi1_axi4_top.sv
tb_pi1_axi4.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_pi1_axi4
FLIST     ?= pi1_axi4.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -j 0
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
